// ==== vlog.f ====
+incdir+tests
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := cpu_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tests/program.svh
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/program.svh ====
`ifndef program_svh
`define program_svh

// program: one 16-bit word per address, assembly in the comment
// expected: (register, value) pairs in write-back order

localparam int prog_len = 25;
localparam int num_wb   = 15;

localparam logic [15:0] prog_words [prog_len] = '{
    16'h6825,   //  0  li    r1, 0x25
    16'h6843,   //  1  li    r2, 0x43
    16'hE14D,   //  2  addu  r3 = r1 + r2
    16'hE333,   //  3  subu  r4 = r3 - r1
    16'h4CA1,   //  4  addiu r5 = r4 + 0xa1 (negative)
    16'h4B3C,   //  5  addiu r1 = r3 + 0x3c
    16'hDAA3,   //  6  sw    r5 -> [r2 + 3]
    16'h9AC3,   //  7  lw    r6 <- [r2 + 3]
    16'hE63D,   //  8  addu  r7 = r6 + r1, load-use
    16'h2805,   //  9  bnez  r0, +5, not taken
    16'h686A,   // 10  li    r3, 0x6a
    16'h2002,   // 11  beqz  r0, +2, taken
    16'h68FF,   // 12  squashed
    16'h68FF,   // 13  squashed
    16'h4B21,   // 14  addiu r1 = r3 + 0x21
    16'h1002,   // 15  b     +2
    16'h68FF,   // 16  squashed
    16'h68FF,   // 17  squashed
    16'hE18B,   // 18  subu  r2 = r1 - r4
    16'h2205,   // 19  beqz  r2, +5, not taken
    16'hE2A1,   // 20  addu  r0 = r2 + r5
    16'h9A9E,   // 21  lw    r4 <- [r2 - 2]
    16'hDA80,   // 22  sw    r4 -> [r2], load-use on store data
    16'h9AA0,   // 23  lw    r5 <- [r2]
    16'hE0BB    // 24  subu  r6 = r0 - r5, load-use
};

// what a squashed li would write
localparam logic [2:0]  squash_reg = 3'd7;
localparam logic [15:0] squash_val = 16'h00FF;

localparam logic [2:0] exp_reg [num_wb] = '{
    3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd1, 3'd6, 3'd7,
    3'd3, 3'd1, 3'd2, 3'd0, 3'd4, 3'd5, 3'd6
};

localparam logic [15:0] exp_val [num_wb] = '{
    16'h0025, 16'h0043, 16'h0068, 16'h0043, 16'hFFE4, 16'h00A4, 16'hFFE4, 16'h0088,
    16'h006A, 16'h008B, 16'h0048, 16'h002C, 16'hFFE4, 16'hFFE4, 16'h0048
};

`endif

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    `include "program.svh"

    localparam int timeout_cycles = 500;
    localparam int drain_cycles   = 20;
    localparam logic [15:0] nop_word = {cpu_pkg::op_nop, 11'd0};

    logic           clk_50MHz;
    logic           rst;
    logic [15:0]    pc;
    cpu_pkg::inst_t inst;
    logic           wb_en;
    logic [2:0]     wb_addr;
    logic [15:0]    wb_data;

    int wb_count;
    int errors;
    int timeouts;
    int cycles;

    cpu_top DUT (
        .clk_50MHz(clk_50MHz),
        .rst(rst),
        .pc(pc),
        .inst(inst),
        .wb_en(wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // instruction ROM, NOP past the end of the program
    function automatic logic [15:0] rom_word(input logic [15:0] addr);
        if (int'(addr) < prog_len) begin
            return prog_words[addr];
        end
        return nop_word;
    endfunction

    always @(posedge clk_50MHz) begin
        #1;
        inst = rom_word(pc);
    end

    // position in the expected list
    always @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_count <= 0;
        end else if (wb_en) begin
            wb_count <= wb_count + 1;
        end
    end

    // checks run on the falling edge, when DUT outputs are settled
    a_reset_pc: assert property (@(negedge clk_50MHz)
        (!rst || $rose(rst)) |-> pc == '0)
        else begin
            errors = errors + 1;
            $display("** Error at %0d ns: pc expected 16'h0000, got 16'h%h", $time, pc);
        end

    a_reset_wb_en: assert property (@(negedge clk_50MHz)
        (!rst || $rose(rst)) |-> !wb_en)
        else begin
            errors = errors + 1;
            $display("** Error at %0d ns: wb_en expected 0, got %b", $time, wb_en);
        end

    a_wb_expected: assert property (@(negedge clk_50MHz) disable iff (!rst)
        wb_en |-> wb_count < num_wb)
        else begin
            errors = errors + 1;
            $display("unexpected write-back at %0d ns: r%0d <= 16'h%h after all %0d writes",
                     $time, wb_addr, wb_data, num_wb);
        end

    a_wb_addr: assert property (@(negedge clk_50MHz) disable iff (!rst)
        wb_en && wb_count < num_wb |-> wb_addr == exp_reg[wb_count])
        else begin
            errors = errors + 1;
            $display("** Error at %0d ns: wb_addr expected %0d, got %0d (write-back %0d)",
                     $time, exp_reg[wb_count], wb_addr, wb_count);
        end

    a_wb_data: assert property (@(negedge clk_50MHz) disable iff (!rst)
        wb_en && wb_count < num_wb |-> wb_data == exp_val[wb_count])
        else begin
            errors = errors + 1;
            $display("** Error at %0d ns: wb_data expected 16'h%h, got 16'h%h (write-back %0d)",
                     $time, exp_val[wb_count], wb_data, wb_count);
        end

    // instructions behind a taken branch must never reach write-back
    a_no_squashed_write: assert property (@(negedge clk_50MHz) disable iff (!rst)
        wb_en |-> !(wb_addr == squash_reg && wb_data == squash_val))
        else begin
            errors = errors + 1;
            $display("squashed instruction wrote back at %0d ns: r%0d <= 16'h%h",
                     $time, wb_addr, wb_data);
        end

    initial begin
        clk_50MHz = 1'b0;
        rst       = 1'b1;
        inst      = nop_word;
        errors    = 0;
        timeouts  = 0;
        cycles    = 0;
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk_50MHz);
        #1;
        rst = 1'b1;

        while (wb_count < num_wb && cycles < timeout_cycles) begin
            @(negedge clk_50MHz);
            cycles = cycles + 1;
        end
        if (wb_count < num_wb) begin
            timeouts = timeouts + 1;
            $display("timeout: only %0d of %0d write-backs arrived within %0d cycles",
                     wb_count, num_wb, timeout_cycles);
        end else begin
            // quiet period, any late write trips a_wb_expected
            repeat (drain_cycles) @(negedge clk_50MHz);
        end

        $display("write-backs %0d of %0d, errors %0d, timeouts %0d",
                 wb_count, num_wb, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                               clk_50MHz,
    input  logic                               rst,
    output logic [cpu_pkg::data_width-1:0]     pc,
    input  cpu_pkg::inst_t                     inst,
    output logic                               wb_en,
    output logic [cpu_pkg::reg_addr_width-1:0] wb_addr,
    output logic [cpu_pkg::data_width-1:0]     wb_data
);

    logic                               stall;
    logic                               branch_taken;
    logic [cpu_pkg::data_width-1:0]     branch_target;
    cpu_pkg::inst_t                     id_inst;
    logic [cpu_pkg::data_width-1:0]     id_pc_next;
    logic [1:0]                         alu_op;
    logic                               use_imm;
    logic [cpu_pkg::data_width-1:0]     imm;
    logic [cpu_pkg::reg_addr_width-1:0] rd;
    logic                               reg_write;
    logic                               mem_read;
    logic                               mem_write;
    logic                               wb_sel;
    logic [1:0]                         br_cond;
    logic [cpu_pkg::data_width-1:0]     ra_data;
    logic [cpu_pkg::data_width-1:0]     rb_data;
    logic [cpu_pkg::reg_addr_width-1:0] ex_rx;
    logic [cpu_pkg::reg_addr_width-1:0] ex_ry;
    logic [cpu_pkg::reg_addr_width-1:0] ex_rd;
    logic                               ex_mem_read;
    logic [1:0]                         fwd_a;
    logic [1:0]                         fwd_b;
    logic [cpu_pkg::data_width-1:0]     mem_fwd_data;
    logic [cpu_pkg::data_width-1:0]     exm_alu_result;
    logic [cpu_pkg::data_width-1:0]     exm_store_data;
    logic [cpu_pkg::reg_addr_width-1:0] exm_rd;
    logic                               exm_reg_write;
    logic                               exm_mem_read;
    logic                               exm_mem_write;
    logic                               exm_wb_sel;

    fetch_stage u_fetch (
        .clk_50MHz(clk_50MHz), .rst(rst), .stall(stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .inst(inst), .pc(pc), .id_inst(id_inst),
        .id_pc_next(id_pc_next)
    );

    decoder u_decoder (
        .id_inst(id_inst), .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .rd(rd),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .wb_sel(wb_sel), .br_cond(br_cond)
    );

    // sources are always rx and ry of the register-register view
    reg_file u_regs (
        .clk_50MHz(clk_50MHz), .rst(rst), .ra_addr(id_inst.rrr.rx),
        .rb_addr(id_inst.rrr.ry), .ra_data(ra_data), .rb_data(rb_data),
        .we(wb_en), .waddr(wb_addr), .wdata(wb_data)
    );

    hazard_unit u_hazard (
        .id_rx(id_inst.rrr.rx), .id_ry(id_inst.rrr.ry), .ex_rx(ex_rx), .ex_ry(ex_ry),
        .ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .mem_rd(exm_rd),
        .mem_reg_write(exm_reg_write), .wb_rd(wb_addr), .wb_reg_write(wb_en),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage u_execute (
        .clk_50MHz(clk_50MHz), .rst(rst), .stall(stall), .flush(branch_taken),
        .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .rd(rd), .reg_write(reg_write),
        .mem_read(mem_read), .mem_write(mem_write), .wb_sel(wb_sel), .br_cond(br_cond),
        .ra_data(ra_data), .rb_data(rb_data), .id_rx(id_inst.rrr.rx),
        .id_ry(id_inst.rrr.ry), .id_pc_next(id_pc_next), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd_data(mem_fwd_data), .wb_fwd_data(wb_data), .ex_rx(ex_rx), .ex_ry(ex_ry),
        .ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .branch_taken(branch_taken),
        .branch_target(branch_target), .exm_alu_result(exm_alu_result),
        .exm_store_data(exm_store_data), .exm_rd(exm_rd), .exm_reg_write(exm_reg_write),
        .exm_mem_read(exm_mem_read), .exm_mem_write(exm_mem_write),
        .exm_wb_sel(exm_wb_sel)
    );

    mem_wb_stage u_mem_wb (
        .clk_50MHz(clk_50MHz), .rst(rst), .exm_alu_result(exm_alu_result),
        .exm_store_data(exm_store_data), .exm_rd(exm_rd), .exm_reg_write(exm_reg_write),
        .exm_mem_read(exm_mem_read), .exm_mem_write(exm_mem_write),
        .exm_wb_sel(exm_wb_sel), .mem_fwd_data(mem_fwd_data), .wb_en(wb_en),
        .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

// ==== logic/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                               clk_50MHz,
    input  logic                               rst,
    input  logic [cpu_pkg::data_width-1:0]     exm_alu_result,
    input  logic [cpu_pkg::data_width-1:0]     exm_store_data,
    input  logic [cpu_pkg::reg_addr_width-1:0] exm_rd,
    input  logic                               exm_reg_write,
    input  logic                               exm_mem_read,
    input  logic                               exm_mem_write,
    input  logic                               exm_wb_sel,
    output logic [cpu_pkg::data_width-1:0]     mem_fwd_data,
    output logic                               wb_en,
    output logic [cpu_pkg::reg_addr_width-1:0] wb_addr,
    output logic [cpu_pkg::data_width-1:0]     wb_data
);

    localparam int dmem_addr_width = $clog2(cpu_pkg::dmem_depth);

    logic [cpu_pkg::data_width-1:0] dmem [cpu_pkg::dmem_depth];
    logic [dmem_addr_width-1:0]     dmem_addr;
    logic [cpu_pkg::data_width-1:0] dmem_rdata;
    logic                           wb_sel_q;
    logic [cpu_pkg::data_width-1:0] wb_alu;
    logic [cpu_pkg::data_width-1:0] wb_mem;

    assign dmem_addr  = exm_alu_result[dmem_addr_width-1:0];
    assign dmem_rdata = dmem[dmem_addr];

    always_ff @(posedge clk_50MHz) begin
        if (exm_mem_write) begin
            dmem[dmem_addr] <= exm_store_data;
        end
    end

    // value seen by execute when it reads this stage's result
    assign mem_fwd_data = exm_mem_read ? dmem_rdata : exm_alu_result;

    // MEM/WB register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_en    <= 1'b0;
            wb_addr  <= '0;
            wb_sel_q <= cpu_pkg::wb_sel_alu;
        end else begin
            wb_en    <= exm_reg_write;
            wb_addr  <= exm_rd;
            wb_sel_q <= exm_wb_sel;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        wb_alu <= exm_alu_result;
        wb_mem <= dmem_rdata;
    end

    assign wb_data = (wb_sel_q == cpu_pkg::wb_sel_mem) ? wb_mem : wb_alu;

    a_dmem_in_range: assert property (@(posedge clk_50MHz) disable iff (!rst)
        (exm_mem_read || exm_mem_write) |-> exm_alu_result < cpu_pkg::dmem_depth);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                               clk_50MHz,
    input  logic                               rst,
    input  logic                               stall,
    input  logic                               flush,
    input  logic [1:0]                         alu_op,
    input  logic                               use_imm,
    input  logic [cpu_pkg::data_width-1:0]     imm,
    input  logic [cpu_pkg::reg_addr_width-1:0] rd,
    input  logic                               reg_write,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic                               wb_sel,
    input  logic [1:0]                         br_cond,
    input  logic [cpu_pkg::data_width-1:0]     ra_data,
    input  logic [cpu_pkg::data_width-1:0]     rb_data,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_rx,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_ry,
    input  logic [cpu_pkg::data_width-1:0]     id_pc_next,
    input  logic [1:0]                         fwd_a,
    input  logic [1:0]                         fwd_b,
    input  logic [cpu_pkg::data_width-1:0]     mem_fwd_data,
    input  logic [cpu_pkg::data_width-1:0]     wb_fwd_data,
    output logic [cpu_pkg::reg_addr_width-1:0] ex_rx,
    output logic [cpu_pkg::reg_addr_width-1:0] ex_ry,
    output logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
    output logic                               ex_mem_read,
    output logic                               branch_taken,
    output logic [cpu_pkg::data_width-1:0]     branch_target,
    output logic [cpu_pkg::data_width-1:0]     exm_alu_result,
    output logic [cpu_pkg::data_width-1:0]     exm_store_data,
    output logic [cpu_pkg::reg_addr_width-1:0] exm_rd,
    output logic                               exm_reg_write,
    output logic                               exm_mem_read,
    output logic                               exm_mem_write,
    output logic                               exm_wb_sel
);

    logic                           ex_reg_write;
    logic                           ex_mem_write;
    logic [1:0]                     ex_br_cond;
    logic [1:0]                     ex_alu_op;
    logic                           ex_use_imm;
    logic                           ex_wb_sel;
    logic [cpu_pkg::data_width-1:0] ex_imm;
    logic [cpu_pkg::data_width-1:0] ex_ra;
    logic [cpu_pkg::data_width-1:0] ex_rb;
    logic [cpu_pkg::data_width-1:0] ex_pc_next;
    logic [cpu_pkg::data_width-1:0] op_a;
    logic [cpu_pkg::data_width-1:0] op_b;
    logic [cpu_pkg::data_width-1:0] alu_b;
    logic [cpu_pkg::data_width-1:0] alu_result;

    function automatic logic [cpu_pkg::data_width-1:0] fwd_mux(
        input logic [1:0]                     sel,
        input logic [cpu_pkg::data_width-1:0] reg_val
    );
        case (sel)
            cpu_pkg::fwd_mem: return mem_fwd_data;
            cpu_pkg::fwd_wb:  return wb_fwd_data;
            default:          return reg_val;
        endcase
    endfunction

    // ID/EXE control, a bubble on stall or flush
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_br_cond   <= cpu_pkg::br_none;
        end else if (stall || flush) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_br_cond   <= cpu_pkg::br_none;
        end else begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_br_cond   <= br_cond;
        end
    end

    // ID/EXE payload
    always_ff @(posedge clk_50MHz) begin
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
        ex_wb_sel  <= wb_sel;
        ex_imm     <= imm;
        ex_rd      <= rd;
        ex_rx      <= id_rx;
        ex_ry      <= id_ry;
        ex_ra      <= ra_data;
        ex_rb      <= rb_data;
        ex_pc_next <= id_pc_next;
    end

    always_comb begin
        op_a = fwd_mux(fwd_a, ex_ra);
        op_b = fwd_mux(fwd_b, ex_rb);
    end

    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_sub:    alu_result = op_a - alu_b;
            cpu_pkg::alu_pass_b: alu_result = alu_b;
            default:             alu_result = op_a + alu_b;
        endcase
    end

    // branch resolved here, offset is relative to the next pc
    assign branch_target = ex_pc_next + ex_imm;

    always_comb begin
        case (ex_br_cond)
            cpu_pkg::br_always:  branch_taken = 1'b1;
            cpu_pkg::br_zero:    branch_taken = (op_a == '0);
            cpu_pkg::br_nonzero: branch_taken = (op_a != '0);
            default:             branch_taken = 1'b0;
        endcase
    end

    // EXE/MEM, never held
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            exm_reg_write <= 1'b0;
            exm_mem_read  <= 1'b0;
            exm_mem_write <= 1'b0;
        end else begin
            exm_reg_write <= ex_reg_write;
            exm_mem_read  <= ex_mem_read;
            exm_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        exm_alu_result <= alu_result;
        exm_store_data <= op_b;
        exm_rd         <= ex_rd;
        exm_wb_sel     <= ex_wb_sel;
    end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_width-1:0] id_rx,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_ry,
    input  logic [cpu_pkg::reg_addr_width-1:0] ex_rx,
    input  logic [cpu_pkg::reg_addr_width-1:0] ex_ry,
    input  logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
    input  logic                               ex_mem_read,
    input  logic [cpu_pkg::reg_addr_width-1:0] mem_rd,
    input  logic                               mem_reg_write,
    input  logic [cpu_pkg::reg_addr_width-1:0] wb_rd,
    input  logic                               wb_reg_write,
    output logic                               stall,
    output logic [1:0]                         fwd_a,
    output logic [1:0]                         fwd_b
);

    // the younger producer is closer, so memory is checked first
    function automatic logic [1:0] pick_source(
        input logic [cpu_pkg::reg_addr_width-1:0] src
    );
        if (mem_reg_write && mem_rd == src) begin
            return cpu_pkg::fwd_mem;
        end else if (wb_reg_write && wb_rd == src) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_none;
    endfunction

    // load data is only ready in the memory stage, one cycle too late
    always_comb begin
        stall = ex_mem_read && (ex_rd == id_rx || ex_rd == id_ry);
    end

    always_comb begin
        fwd_a = pick_source(ex_rx);
        fwd_b = pick_source(ex_ry);
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                               clk_50MHz,
    input  logic                               rst,
    input  logic [cpu_pkg::reg_addr_width-1:0] ra_addr,
    input  logic [cpu_pkg::reg_addr_width-1:0] rb_addr,
    output logic [cpu_pkg::data_width-1:0]     ra_data,
    output logic [cpu_pkg::data_width-1:0]     rb_data,
    input  logic                               we,
    input  logic [cpu_pkg::reg_addr_width-1:0] waddr,
    input  logic [cpu_pkg::data_width-1:0]     wdata
);

    localparam int num_regs = 2 ** cpu_pkg::reg_addr_width;

    logic [cpu_pkg::data_width-1:0] regs [num_regs];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value being written back
    assign ra_data = (we && waddr == ra_addr) ? wdata : regs[ra_addr];
    assign rb_data = (we && waddr == rb_addr) ? wdata : regs[rb_addr];

    a_waddr_known: assert property (@(posedge clk_50MHz) disable iff (!rst)
        we |-> !$isunknown(waddr));

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::inst_t                     id_inst,
    output logic [1:0]                         alu_op,
    output logic                               use_imm,
    output logic [cpu_pkg::data_width-1:0]     imm,
    output logic [cpu_pkg::reg_addr_width-1:0] rd,
    output logic                               reg_write,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               wb_sel,
    output logic [1:0]                         br_cond
);

    logic [cpu_pkg::data_width-1:0] sext_imm8;
    logic [cpu_pkg::data_width-1:0] zext_imm8;
    logic [cpu_pkg::data_width-1:0] sext_imm5;
    logic [cpu_pkg::data_width-1:0] sext_off11;

    // immediates in every width the formats use
    assign sext_imm8  = {{(cpu_pkg::data_width-8){id_inst.ri.imm[7]}}, id_inst.ri.imm};
    assign zext_imm8  = {{(cpu_pkg::data_width-8){1'b0}}, id_inst.ri.imm};
    assign sext_imm5  = {{(cpu_pkg::data_width-5){id_inst.ri.imm[4]}}, id_inst.ri.imm[4:0]};
    assign sext_off11 = {{(cpu_pkg::data_width-11){id_inst.i11.offset[10]}},
                         id_inst.i11.offset};

    always_comb begin
        alu_op    = cpu_pkg::alu_add;
        use_imm   = 1'b1;
        imm       = sext_imm8;
        rd        = id_inst.rrr.ry;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        wb_sel    = cpu_pkg::wb_sel_alu;
        br_cond   = cpu_pkg::br_none;
        case (id_inst.rrr.op)
            cpu_pkg::op_addu_subu: begin
                use_imm   = 1'b0;
                rd        = id_inst.rrr.rz;
                reg_write = (id_inst.rrr.fn == cpu_pkg::fn_addu) ||
                            (id_inst.rrr.fn == cpu_pkg::fn_subu);
                if (id_inst.rrr.fn == cpu_pkg::fn_subu) begin
                    alu_op = cpu_pkg::alu_sub;
                end
            end
            cpu_pkg::op_addiu: reg_write = 1'b1;
            cpu_pkg::op_li: begin
                imm       = zext_imm8;
                alu_op    = cpu_pkg::alu_pass_b;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lw: begin
                imm       = sext_imm5;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = cpu_pkg::wb_sel_mem;
            end
            cpu_pkg::op_sw: begin
                imm       = sext_imm5;
                mem_write = 1'b1;
            end
            cpu_pkg::op_b: begin
                imm     = sext_off11;
                br_cond = cpu_pkg::br_always;
            end
            cpu_pkg::op_beqz: br_cond = cpu_pkg::br_zero;
            cpu_pkg::op_bnez: br_cond = cpu_pkg::br_nonzero;
            // nop and unknown opcodes change nothing
            default: ;
        endcase
    end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                           clk_50MHz,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           branch_taken,
    input  logic [cpu_pkg::data_width-1:0] branch_target,
    input  cpu_pkg::inst_t                 inst,
    output logic [cpu_pkg::data_width-1:0] pc,
    output cpu_pkg::inst_t                 id_inst,
    output logic [cpu_pkg::data_width-1:0] id_pc_next
);

    localparam cpu_pkg::inst_t nop_inst = {cpu_pkg::op_nop, 11'd0};

    logic [cpu_pkg::data_width-1:0] pc_plus_one;

    assign pc_plus_one = pc + 1'b1;

    // a redirect wins over a stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_plus_one;
        end
    end

    // IF/ID register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_inst    <= nop_inst;
            id_pc_next <= '0;
        end else if (branch_taken) begin
            id_inst <= nop_inst;
        end else if (!stall) begin
            id_inst    <= inst;
            id_pc_next <= pc_plus_one;
        end
    end

    a_stall_holds_pc: assert property (@(posedge clk_50MHz) disable iff (!rst)
        stall && !branch_taken |=> $stable(pc));

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // datapath sizes
    localparam int data_width     = 16;
    localparam int reg_addr_width = 3;
    localparam int dmem_depth     = 256;

    // major opcodes, top five bits of every instruction
    localparam logic [4:0] op_addu_subu = 5'b11100;
    localparam logic [4:0] op_addiu     = 5'b01001;
    localparam logic [4:0] op_li        = 5'b01101;
    localparam logic [4:0] op_lw        = 5'b10011;
    localparam logic [4:0] op_sw        = 5'b11011;
    localparam logic [4:0] op_b         = 5'b00010;
    localparam logic [4:0] op_beqz      = 5'b00100;
    localparam logic [4:0] op_bnez      = 5'b00101;
    localparam logic [4:0] op_nop       = 5'b00001;

    // function field of the register-register format
    localparam logic [1:0] fn_addu = 2'b01;
    localparam logic [1:0] fn_subu = 2'b11;

    localparam logic [1:0] alu_add    = 2'd0;
    localparam logic [1:0] alu_sub    = 2'd1;
    localparam logic [1:0] alu_pass_b = 2'd2;

    localparam logic wb_sel_alu = 1'b0;
    localparam logic wb_sel_mem = 1'b1;

    // operand source in execute
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem  = 2'd1;
    localparam logic [1:0] fwd_wb   = 2'd2;

    localparam logic [1:0] br_none    = 2'd0;
    localparam logic [1:0] br_always  = 2'd1;
    localparam logic [1:0] br_zero    = 2'd2;
    localparam logic [1:0] br_nonzero = 2'd3;

    // one instruction word, three readings of the low eleven bits
    typedef union packed {
        struct packed {
            logic [4:0]                op;
            logic [reg_addr_width-1:0] rx;
            logic [reg_addr_width-1:0] ry;
            logic [reg_addr_width-1:0] rz;
            logic [1:0]                fn;
        } rrr;
        struct packed {
            logic [4:0]                op;
            logic [reg_addr_width-1:0] rx;
            logic [7:0]                imm;
        } ri;
        struct packed {
            logic [4:0]  op;
            logic [10:0] offset;
        } i11;
    } inst_t;

endpackage
